/* soc_settings.svh */
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// CLINT address window
`define CLINT_BASE 32'h0200_0000
`define CLINT_SIZE 32'h0001_0000

// CLINT register offsets inside the window
`define MTIMECMP_LO 16'h4000
`define MTIMECMP_HI 16'h4004
`define MTIME_LO 16'hBFF8
`define MTIME_HI 16'hBFFC

// ID carried by every transaction
`define AXI_ID 4'h1

// Clocks per mtime tick
`define MTIME_DIV 1

// Single-beat transfer shape on io_master
`define AXI_LEN_SINGLE 8'd0
`define AXI_SIZE_WORD 3'd2
`define AXI_BURST_INCR 2'b01

`endif

/* soc_pkg.sv */
package soc_pkg;

  // AXI response codes in use
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // Where the outstanding transaction went
  typedef enum logic {
    TGT_EXT   = 1'b0,
    TGT_CLINT = 1'b1
  } xbar_target_e;

  // One core load or store
  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
  } mem_req_t;

endpackage

/* soc_axi_if.sv */
`timescale 1ns/1ps

interface soc_axi_if;

  logic        awvalid;
  logic        awready;
  logic [31:0] awaddr;
  logic [3:0]  awid;

  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wlast;

  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic [3:0]  bid;

  logic        arvalid;
  logic        arready;
  logic [31:0] araddr;
  logic [3:0]  arid;

  logic        rvalid;
  logic        rready;
  logic [1:0]  rresp;
  logic [31:0] rdata;
  logic        rlast;
  logic [3:0]  rid;

  modport master (
    output awvalid, awaddr, awid,
    input  awready,
    output wvalid, wdata, wstrb, wlast,
    input  wready,
    input  bvalid, bresp, bid,
    output bready,
    output arvalid, araddr, arid,
    input  arready,
    input  rvalid, rresp, rdata, rlast, rid,
    output rready
  );

  modport slave (
    input  awvalid, awaddr, awid,
    output awready,
    input  wvalid, wdata, wstrb, wlast,
    output wready,
    output bvalid, bresp, bid,
    input  bready,
    input  arvalid, araddr, arid,
    output arready,
    output rvalid, rresp, rdata, rlast, rid,
    input  rready
  );

endinterface

/* lsu_axi_bridge.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module lsu_axi_bridge (
  input  logic        clock,
  input  logic        reset_i,
  input  logic        req_valid_i,
  input  logic        req_write_i,
  input  logic [31:0] req_addr_i,
  input  logic [31:0] req_wdata_i,
  input  logic [3:0]  req_wstrb_i,
  output logic        req_ready_o,
  output logic        resp_valid_o,
  output logic [31:0] resp_rdata_o,
  output logic        resp_err_o,
  soc_axi_if.master   axi
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_BUSY,
    S_DONE
  } state_e;

  state_e      state_q;
  mem_req_t    req_q;
  logic        aw_pend_q;
  logic        w_pend_q;
  logic        ar_pend_q;
  logic [31:0] rdata_q;
  logic        err_q;
  logic        b_beat;
  logic        r_beat;

  assign b_beat = axi.bvalid && axi.bready;
  assign r_beat = axi.rvalid && axi.rready;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q   <= S_IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      ar_pend_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (req_valid_i) begin
            aw_pend_q <= req_write_i;
            w_pend_q  <= req_write_i;
            ar_pend_q <= !req_write_i;
            state_q   <= S_BUSY;
          end
        end
        S_BUSY: begin
          // AW and W retire on their own handshakes
          if (axi.awready) begin
            aw_pend_q <= 1'b0;
          end
          if (axi.wready) begin
            w_pend_q <= 1'b0;
          end
          if (axi.arready) begin
            ar_pend_q <= 1'b0;
          end
          if (b_beat || r_beat) begin
            state_q <= S_DONE;
          end
        end
        S_DONE: state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (req_ready_o && req_valid_i) begin
      req_q <= '{write: req_write_i, addr: req_addr_i, data: req_wdata_i, strb: req_wstrb_i};
    end
    if (b_beat) begin
      rdata_q <= '0;
      err_q   <= (axi.bresp != OKAY);
    end else if (r_beat) begin
      rdata_q <= axi.rdata;
      err_q   <= (axi.rresp != OKAY);
    end
  end

  assign req_ready_o  = (state_q == S_IDLE);
  assign resp_valid_o = (state_q == S_DONE);
  assign resp_rdata_o = rdata_q;
  assign resp_err_o   = err_q;

  assign axi.awvalid = aw_pend_q;
  assign axi.awaddr  = req_q.addr;
  assign axi.awid    = `AXI_ID;
  assign axi.wvalid  = w_pend_q;
  assign axi.wdata   = req_q.data;
  assign axi.wstrb   = req_q.strb;
  assign axi.wlast   = 1'b1;
  assign axi.bready  = (state_q == S_BUSY) && req_q.write;
  assign axi.arvalid = ar_pend_q;
  assign axi.araddr  = req_q.addr;
  assign axi.arid    = `AXI_ID;
  assign axi.rready  = (state_q == S_BUSY) && !req_q.write;

endmodule

/* clint_xbar.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module clint_xbar (
  input  logic      clock,
  input  logic      reset_i,
  soc_axi_if.slave  axi,
  soc_axi_if.master axi_clint,
  soc_axi_if.master axi_soc
);
  import soc_pkg::*;

  xbar_target_e aw_dec;
  xbar_target_e ar_dec;
  xbar_target_e w_tgt;
  xbar_target_e tgt_q;
  logic         busy_q;
  logic         addr_acc;
  logic         resp_done;

  function automatic xbar_target_e decode(input logic [31:0] addr);
    if ((addr >= `CLINT_BASE) && (addr < (`CLINT_BASE + `CLINT_SIZE))) begin
      return TGT_CLINT;
    end
    return TGT_EXT;
  endfunction

  assign aw_dec = decode(axi.awaddr);
  assign ar_dec = decode(axi.araddr);
  // W may trail AW, so follow the latched target once AW is taken
  assign w_tgt  = busy_q ? tgt_q : aw_dec;

  assign addr_acc  = (axi.awvalid && axi.awready) || (axi.arvalid && axi.arready);
  assign resp_done = (axi.bvalid && axi.bready) || (axi.rvalid && axi.rready);

  always_ff @(posedge clock) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      tgt_q  <= TGT_EXT;
    end else if (addr_acc) begin
      busy_q <= 1'b1;
      tgt_q  <= axi.awvalid ? aw_dec : ar_dec;
    end else if (resp_done) begin
      busy_q <= 1'b0;
      tgt_q  <= TGT_EXT;
    end
  end

  // Payloads go to both sides, valids only to the selected one
  assign axi_clint.awvalid = axi.awvalid && (aw_dec == TGT_CLINT);
  assign axi_soc.awvalid   = axi.awvalid && (aw_dec == TGT_EXT);
  assign axi_clint.awaddr  = axi.awaddr;
  assign axi_soc.awaddr    = axi.awaddr;
  assign axi_clint.awid    = axi.awid;
  assign axi_soc.awid      = axi.awid;
  assign axi.awready = (aw_dec == TGT_CLINT) ? axi_clint.awready : axi_soc.awready;

  assign axi_clint.wvalid = axi.wvalid && (w_tgt == TGT_CLINT);
  assign axi_soc.wvalid   = axi.wvalid && (w_tgt == TGT_EXT);
  assign axi_clint.wdata  = axi.wdata;
  assign axi_soc.wdata    = axi.wdata;
  assign axi_clint.wstrb  = axi.wstrb;
  assign axi_soc.wstrb    = axi.wstrb;
  assign axi_clint.wlast  = axi.wlast;
  assign axi_soc.wlast    = axi.wlast;
  assign axi.wready = (w_tgt == TGT_CLINT) ? axi_clint.wready : axi_soc.wready;

  assign axi_clint.arvalid = axi.arvalid && (ar_dec == TGT_CLINT);
  assign axi_soc.arvalid   = axi.arvalid && (ar_dec == TGT_EXT);
  assign axi_clint.araddr  = axi.araddr;
  assign axi_soc.araddr    = axi.araddr;
  assign axi_clint.arid    = axi.arid;
  assign axi_soc.arid      = axi.arid;
  assign axi.arready = (ar_dec == TGT_CLINT) ? axi_clint.arready : axi_soc.arready;

  // Responses steered by the latched target
  assign axi_clint.bready = axi.bready && busy_q && (tgt_q == TGT_CLINT);
  assign axi_soc.bready   = axi.bready && busy_q && (tgt_q == TGT_EXT);
  assign axi.bvalid = busy_q && ((tgt_q == TGT_CLINT) ? axi_clint.bvalid : axi_soc.bvalid);
  assign axi.bresp  = (tgt_q == TGT_CLINT) ? axi_clint.bresp : axi_soc.bresp;
  assign axi.bid    = (tgt_q == TGT_CLINT) ? axi_clint.bid : axi_soc.bid;

  assign axi_clint.rready = axi.rready && busy_q && (tgt_q == TGT_CLINT);
  assign axi_soc.rready   = axi.rready && busy_q && (tgt_q == TGT_EXT);
  assign axi.rvalid = busy_q && ((tgt_q == TGT_CLINT) ? axi_clint.rvalid : axi_soc.rvalid);
  assign axi.rresp  = (tgt_q == TGT_CLINT) ? axi_clint.rresp : axi_soc.rresp;
  assign axi.rdata  = (tgt_q == TGT_CLINT) ? axi_clint.rdata : axi_soc.rdata;
  assign axi.rlast  = (tgt_q == TGT_CLINT) ? axi_clint.rlast : axi_soc.rlast;
  assign axi.rid    = (tgt_q == TGT_CLINT) ? axi_clint.rid : axi_soc.rid;

endmodule

/* clint.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module clint (
  input  logic     clock,
  input  logic     reset_i,
  soc_axi_if.slave axi,
  output logic     timer_irq_o
);
  import soc_pkg::*;

  localparam int DIV_W = $clog2(`MTIME_DIV + 1);

  logic [DIV_W-1:0] div_cnt_q;
  logic             tick;
  logic [63:0]      mtime_q;
  logic [63:0]      mtimecmp_q;
  logic             irq_q;
  logic             idle;
  logic             wr_go;
  logic             rd_go;
  logic [15:0]      wr_off;
  logic [15:0]      rd_off;
  logic             bvalid_q;
  logic             rvalid_q;
  axi_resp_e        bresp_q;
  axi_resp_e        rresp_q;
  logic [3:0]       bid_q;
  logic [3:0]       rid_q;
  logic [31:0]      rdata_q;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Timebase
  assign tick = (div_cnt_q == DIV_W'(`MTIME_DIV - 1));

  always_ff @(posedge clock) begin
    if (reset_i) begin
      div_cnt_q <= '0;
      mtime_q   <= '0;
      irq_q     <= 1'b0;
    end else begin
      div_cnt_q <= tick ? '0 : div_cnt_q + DIV_W'(1);
      if (tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // Bus side, one access at a time
  assign idle   = !bvalid_q && !rvalid_q;
  assign wr_go  = idle && axi.awvalid && axi.wvalid;
  assign rd_go  = idle && axi.arvalid && !axi.awvalid;
  assign wr_off = axi.awaddr[15:0];
  assign rd_off = axi.araddr[15:0];

  always_ff @(posedge clock) begin
    if (reset_i) begin
      bvalid_q   <= 1'b0;
      rvalid_q   <= 1'b0;
      mtimecmp_q <= '1;
    end else begin
      if (wr_go) begin
        bvalid_q <= 1'b1;
      end else if (axi.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_go) begin
        rvalid_q <= 1'b1;
      end else if (axi.rready) begin
        rvalid_q <= 1'b0;
      end
      if (wr_go && (wr_off == `MTIMECMP_LO)) begin
        mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], axi.wdata, axi.wstrb);
      end
      if (wr_go && (wr_off == `MTIMECMP_HI)) begin
        mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], axi.wdata, axi.wstrb);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr_go) begin
      bid_q <= axi.awid;
      // mtime is read-only
      bresp_q <= ((wr_off == `MTIMECMP_LO) || (wr_off == `MTIMECMP_HI)) ? OKAY : SLVERR;
    end
    if (rd_go) begin
      rid_q   <= axi.arid;
      rresp_q <= OKAY;
      case (rd_off)
        `MTIMECMP_LO: rdata_q <= mtimecmp_q[31:0];
        `MTIMECMP_HI: rdata_q <= mtimecmp_q[63:32];
        `MTIME_LO:    rdata_q <= mtime_q[31:0];
        `MTIME_HI:    rdata_q <= mtime_q[63:32];
        default: begin
          rdata_q <= '0;
          rresp_q <= SLVERR;
        end
      endcase
    end
  end

  assign axi.awready = wr_go;
  assign axi.wready  = wr_go;
  assign axi.arready = rd_go;
  assign axi.bvalid  = bvalid_q;
  assign axi.bresp   = bresp_q;
  assign axi.bid     = bid_q;
  assign axi.rvalid  = rvalid_q;
  assign axi.rresp   = rresp_q;
  assign axi.rdata   = rdata_q;
  assign axi.rlast   = 1'b1;
  assign axi.rid     = rid_q;

  assign timer_irq_o = irq_q;

endmodule

/* soc_top.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_top (
  input  logic        clock,
  input  logic        reset_i,
  // Core load/store port
  input  logic        req_valid_i,
  input  logic        req_write_i,
  input  logic [31:0] req_addr_i,
  input  logic [31:0] req_wdata_i,
  input  logic [3:0]  req_wstrb_i,
  output logic        req_ready_o,
  output logic        resp_valid_o,
  output logic [31:0] resp_rdata_o,
  output logic        resp_err_o,
  output logic        timer_irq_o,
  // AXI4 master
  input  logic        io_master_awready_i,
  output logic        io_master_awvalid_o,
  output logic [31:0] io_master_awaddr_o,
  output logic [3:0]  io_master_awid_o,
  output logic [7:0]  io_master_awlen_o,
  output logic [2:0]  io_master_awsize_o,
  output logic [1:0]  io_master_awburst_o,
  input  logic        io_master_wready_i,
  output logic        io_master_wvalid_o,
  output logic [31:0] io_master_wdata_o,
  output logic [3:0]  io_master_wstrb_o,
  output logic        io_master_wlast_o,
  output logic        io_master_bready_o,
  input  logic        io_master_bvalid_i,
  input  logic [1:0]  io_master_bresp_i,
  input  logic [3:0]  io_master_bid_i,
  input  logic        io_master_arready_i,
  output logic        io_master_arvalid_o,
  output logic [31:0] io_master_araddr_o,
  output logic [3:0]  io_master_arid_o,
  output logic [7:0]  io_master_arlen_o,
  output logic [2:0]  io_master_arsize_o,
  output logic [1:0]  io_master_arburst_o,
  output logic        io_master_rready_o,
  input  logic        io_master_rvalid_i,
  input  logic [1:0]  io_master_rresp_i,
  input  logic [31:0] io_master_rdata_i,
  input  logic        io_master_rlast_i,
  input  logic [3:0]  io_master_rid_i
);

  soc_axi_if axi_core ();
  soc_axi_if axi_clint ();
  soc_axi_if axi_soc ();

  lsu_axi_bridge u_bridge (
    .clock        (clock),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_write_i  (req_write_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_wstrb_i  (req_wstrb_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o),
    .resp_err_o   (resp_err_o),
    .axi          (axi_core)
  );

  clint_xbar u_xbar (
    .clock     (clock),
    .reset_i   (reset_i),
    .axi       (axi_core),
    .axi_clint (axi_clint),
    .axi_soc   (axi_soc)
  );

  clint u_clint (
    .clock       (clock),
    .reset_i     (reset_i),
    .axi         (axi_clint),
    .timer_irq_o (timer_irq_o)
  );

  assign axi_soc.awready     = io_master_awready_i;
  assign io_master_awvalid_o = axi_soc.awvalid;
  assign io_master_awaddr_o  = axi_soc.awaddr;
  assign io_master_awid_o    = axi_soc.awid;
  assign io_master_awlen_o   = `AXI_LEN_SINGLE;
  assign io_master_awsize_o  = `AXI_SIZE_WORD;
  assign io_master_awburst_o = `AXI_BURST_INCR;

  assign axi_soc.wready      = io_master_wready_i;
  assign io_master_wvalid_o  = axi_soc.wvalid;
  assign io_master_wdata_o   = axi_soc.wdata;
  assign io_master_wstrb_o   = axi_soc.wstrb;
  assign io_master_wlast_o   = axi_soc.wlast;

  assign io_master_bready_o  = axi_soc.bready;
  assign axi_soc.bvalid      = io_master_bvalid_i;
  assign axi_soc.bresp       = io_master_bresp_i;
  assign axi_soc.bid         = io_master_bid_i;

  assign axi_soc.arready     = io_master_arready_i;
  assign io_master_arvalid_o = axi_soc.arvalid;
  assign io_master_araddr_o  = axi_soc.araddr;
  assign io_master_arid_o    = axi_soc.arid;
  assign io_master_arlen_o   = `AXI_LEN_SINGLE;
  assign io_master_arsize_o  = `AXI_SIZE_WORD;
  assign io_master_arburst_o = `AXI_BURST_INCR;

  assign io_master_rready_o  = axi_soc.rready;
  assign axi_soc.rvalid      = io_master_rvalid_i;
  assign axi_soc.rresp       = io_master_rresp_i;
  assign axi_soc.rdata       = io_master_rdata_i;
  assign axi_soc.rlast       = io_master_rlast_i;
  assign axi_soc.rid         = io_master_rid_i;

endmodule

/* soc_axi_checker.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_axi_checker (
  input logic        clock,
  input logic        reset_i,
  input logic        req_valid_i,
  input logic        req_ready_o,
  input logic [31:0] req_addr_i,
  input logic        resp_valid_o,
  input logic        io_master_awvalid_o,
  input logic        io_master_awready_i,
  input logic [31:0] io_master_awaddr_o,
  input logic        io_master_wvalid_o,
  input logic        io_master_wready_i,
  input logic [31:0] io_master_wdata_o,
  input logic [3:0]  io_master_wstrb_o,
  input logic        io_master_arvalid_o,
  input logic        io_master_arready_i,
  input logic [31:0] io_master_araddr_o
);
  import soc_pkg::*;

  logic         busy_q;
  xbar_target_e tgt_q;
  logic         in_window;

  assign in_window = (req_addr_i >= `CLINT_BASE) && (req_addr_i < (`CLINT_BASE + `CLINT_SIZE));

  // Core-side view of the access in flight
  always_ff @(posedge clock) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      tgt_q  <= TGT_EXT;
    end else if (req_valid_i && req_ready_o) begin
      busy_q <= 1'b1;
      tgt_q  <= in_window ? TGT_CLINT : TGT_EXT;
    end else if (resp_valid_o) begin
      busy_q <= 1'b0;
    end
  end

  aw_hold: assert property (@(posedge clock) disable iff (reset_i)
    io_master_awvalid_o && !io_master_awready_i |=>
      io_master_awvalid_o && $stable(io_master_awaddr_o))
    else $error("AW valid or address changed before awready");

  w_hold: assert property (@(posedge clock) disable iff (reset_i)
    io_master_wvalid_o && !io_master_wready_i |=>
      io_master_wvalid_o && $stable(io_master_wdata_o) && $stable(io_master_wstrb_o))
    else $error("W valid or payload changed before wready");

  ar_hold: assert property (@(posedge clock) disable iff (reset_i)
    io_master_arvalid_o && !io_master_arready_i |=>
      io_master_arvalid_o && $stable(io_master_araddr_o))
    else $error("AR valid or address changed before arready");

  single_access: assert property (@(posedge clock) disable iff (reset_i)
    !(req_valid_i && req_ready_o && busy_q) && !(io_master_awvalid_o && io_master_arvalid_o))
    else $error("More than one access outstanding");

  resp_pulse: assert property (@(posedge clock) disable iff (reset_i)
    resp_valid_o |=> !resp_valid_o)
    else $error("resp_valid_o held longer than one cycle");

  // CLINT accesses stay off io_master
  clint_quiet: assert property (@(posedge clock) disable iff (reset_i)
    busy_q && (tgt_q == TGT_CLINT) |->
      !(io_master_awvalid_o || io_master_wvalid_o || io_master_arvalid_o))
    else $error("io_master active during a CLINT access");

endmodule

bind soc_top soc_axi_checker u_checker (.*);

/* tb_soc_top.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module tb_soc_top;
  import soc_pkg::*;

  typedef struct {
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] expv;
    logic        err;
  } test_t;

  logic        clock;
  logic        reset_i;
  logic        req_valid_i;
  logic        req_write_i;
  logic [31:0] req_addr_i;
  logic [31:0] req_wdata_i;
  logic [3:0]  req_wstrb_i;
  logic        req_ready_o;
  logic        resp_valid_o;
  logic [31:0] resp_rdata_o;
  logic        resp_err_o;
  logic        timer_irq_o;
  logic        io_master_awready_i;
  logic        io_master_awvalid_o;
  logic [31:0] io_master_awaddr_o;
  logic [3:0]  io_master_awid_o;
  logic [7:0]  io_master_awlen_o;
  logic [2:0]  io_master_awsize_o;
  logic [1:0]  io_master_awburst_o;
  logic        io_master_wready_i;
  logic        io_master_wvalid_o;
  logic [31:0] io_master_wdata_o;
  logic [3:0]  io_master_wstrb_o;
  logic        io_master_wlast_o;
  logic        io_master_bready_o;
  logic        io_master_bvalid_i;
  logic [1:0]  io_master_bresp_i;
  logic [3:0]  io_master_bid_i;
  logic        io_master_arready_i;
  logic        io_master_arvalid_o;
  logic [31:0] io_master_araddr_o;
  logic [3:0]  io_master_arid_o;
  logic [7:0]  io_master_arlen_o;
  logic [2:0]  io_master_arsize_o;
  logic [1:0]  io_master_arburst_o;
  logic        io_master_rready_o;
  logic        io_master_rvalid_i;
  logic [1:0]  io_master_rresp_i;
  logic [31:0] io_master_rdata_i;
  logic        io_master_rlast_i;
  logic [3:0]  io_master_rid_i;

  logic [31:0] mem [256];
  logic [31:0] tm_prev;
  logic        tm_seen = 1'b0;
  int          ext_activity = 0;
  int          cycles = 0;
  int          cycle_limit = 1000;
  int          errors = 0;
  int          checks = 0;

  soc_top u_dut (.*);

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (io_master_awvalid_o || io_master_wvalid_o || io_master_arvalid_o) begin
      ext_activity++;
    end
    if (cycles > cycle_limit) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic int rand_delay();
    return $urandom_range(4, 0);
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clock);
  endtask

  task automatic check_rdata(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input string what, input axi_resp_e got, input axi_resp_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Single-beat shape: length 0, 4-byte size, INCR burst
  task automatic check_addr_beat(input string chan, input logic [3:0] id,
                                 input logic [7:0] len, input logic [2:0] size,
                                 input logic [1:0] burst);
    checks++;
    if ((id !== `AXI_ID) || (len !== 8'd0) || (size !== 3'd2) || (burst !== 2'b01)) begin
      errors++;
      $display("FAILED at %0t: %s beat id %h len %h size %h burst %h, expected single word",
               $time, chan, id, len, size, burst);
    end
  endtask

  // External memory with random ready and valid delays
  task automatic serve_write();
    logic [31:0] addr;
    logic [3:0]  id;
    logic [31:0] wd;
    logic [3:0]  ws;
    wait_cycles(rand_delay());
    #1 io_master_awready_i = 1'b1;
    @(posedge clock);
    addr = io_master_awaddr_o;
    id = io_master_awid_o;
    check_addr_beat("AW", io_master_awid_o, io_master_awlen_o, io_master_awsize_o,
                    io_master_awburst_o);
    #1 io_master_awready_i = 1'b0;
    wait_cycles(rand_delay());
    #1 io_master_wready_i = 1'b1;
    @(posedge clock);
    wd = io_master_wdata_o;
    ws = io_master_wstrb_o;
    check_bit("io_master_wlast_o", io_master_wlast_o, 1'b1);
    #1 io_master_wready_i = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (ws[i]) begin
        mem[addr[9:2]][8*i +: 8] = wd[8*i +: 8];
      end
    end
    wait_cycles(rand_delay());
    #1;
    io_master_bvalid_i = 1'b1;
    io_master_bresp_i = OKAY;
    io_master_bid_i = id;
    do @(posedge clock); while (!io_master_bready_o);
    #1 io_master_bvalid_i = 1'b0;
  endtask

  task automatic serve_read();
    logic [31:0] addr;
    logic [3:0]  id;
    wait_cycles(rand_delay());
    #1 io_master_arready_i = 1'b1;
    @(posedge clock);
    addr = io_master_araddr_o;
    id = io_master_arid_o;
    check_addr_beat("AR", io_master_arid_o, io_master_arlen_o, io_master_arsize_o,
                    io_master_arburst_o);
    #1 io_master_arready_i = 1'b0;
    wait_cycles(rand_delay());
    #1;
    io_master_rvalid_i = 1'b1;
    io_master_rresp_i = OKAY;
    io_master_rdata_i = mem[addr[9:2]];
    io_master_rlast_i = 1'b1;
    io_master_rid_i = id;
    do @(posedge clock); while (!io_master_rready_o);
    #1 io_master_rvalid_i = 1'b0;
  endtask

  initial begin : memory_model
    void'($urandom(32'hfec4));
    io_master_awready_i = 1'b0;
    io_master_wready_i = 1'b0;
    io_master_bvalid_i = 1'b0;
    io_master_bresp_i = 2'b00;
    io_master_bid_i = 4'h0;
    io_master_arready_i = 1'b0;
    io_master_rvalid_i = 1'b0;
    io_master_rresp_i = 2'b00;
    io_master_rdata_i = 32'h0;
    io_master_rlast_i = 1'b0;
    io_master_rid_i = 4'h0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i), 8'hc5, ~8'(i), 8'(i) ^ 8'h3c};
    end
    forever begin
      @(posedge clock);
      if (io_master_awvalid_o) begin
        serve_write();
      end else if (io_master_arvalid_o) begin
        serve_read();
      end
    end
  end

  // One core access, from request to the response pulse
  task automatic do_access(input mem_req_t req, output logic [31:0] rdata,
                           output axi_resp_e resp);
    int   act_before;
    logic in_clint;
    act_before = ext_activity;
    in_clint = (req.addr >= `CLINT_BASE) && (req.addr < (`CLINT_BASE + `CLINT_SIZE));
    req_valid_i = 1'b1;
    req_write_i = req.write;
    req_addr_i = req.addr;
    req_wdata_i = req.data;
    req_wstrb_i = req.strb;
    do @(posedge clock); while (!req_ready_o);
    #1 req_valid_i = 1'b0;
    do @(posedge clock); while (!resp_valid_o);
    rdata = resp_rdata_o;
    resp = resp_err_o ? SLVERR : OKAY;
    #1;
    if (in_clint && (ext_activity != act_before)) begin
      errors++;
      $display("io_master was active during the CLINT access to %h", req.addr);
    end
  endtask

  task automatic run_test(input test_t t);
    mem_req_t    req;
    logic [31:0] rdata;
    logic [31:0] mtime;
    axi_resp_e   resp;
    axi_resp_e   exp_resp;
    logic        seen;
    int          waited;
    exp_resp = t.err ? SLVERR : OKAY;
    case (t.op)
      "wr": begin
        req = '{write: 1'b1, addr: t.addr, data: t.data, strb: t.strb};
        do_access(req, rdata, resp);
        check_resp("write response", resp, exp_resp);
        check_rdata("write response data", rdata, 32'h0);
      end
      "rd": begin
        req = '{write: 1'b0, addr: t.addr, data: '0, strb: '0};
        do_access(req, rdata, resp);
        check_resp("read response", resp, exp_resp);
        if (!t.err) begin
          check_rdata("read data", rdata, t.expv);
        end
      end
      "tm": begin
        req = '{write: 1'b0, addr: t.addr, data: '0, strb: '0};
        do_access(req, rdata, resp);
        check_resp("mtime read response", resp, OKAY);
        if (tm_seen) begin
          checks++;
          if (!(rdata > tm_prev)) begin
            errors++;
            $display("FAILED at %0t: mtime %h did not rise above %h", $time, rdata, tm_prev);
          end
        end
        tm_prev = rdata;
        tm_seen = 1'b1;
      end
      "cmp": begin
        req = '{write: 1'b0, addr: t.addr + `MTIME_LO, data: '0, strb: '0};
        do_access(req, mtime, resp);
        check_resp("mtime read response", resp, OKAY);
        req = '{write: 1'b1, addr: t.addr + `MTIMECMP_LO, data: mtime + t.data, strb: t.strb};
        do_access(req, rdata, resp);
        check_resp("mtimecmp low write response", resp, OKAY);
        req = '{write: 1'b1, addr: t.addr + `MTIMECMP_HI, data: '0, strb: 4'hf};
        do_access(req, rdata, resp);
        check_resp("mtimecmp high write response", resp, OKAY);
        check_bit("timer_irq_o before mtimecmp is reached", timer_irq_o, 1'b0);
        seen = timer_irq_o;
        waited = 0;
        while (!seen && (waited < t.expv)) begin
          @(posedge clock);
          seen = timer_irq_o;
          waited++;
        end
        #1;
        checks++;
        if (!seen) begin
          errors++;
          $display("Timer interrupt did not rise within %0d cycles", t.expv);
        end
      end
      "irq": begin
        wait_cycles(2);
        #1;
        check_bit("timer_irq_o", timer_irq_o, t.expv[0]);
      end
      default: begin
        errors++;
        $display("Unknown operation in testdata line for address %h", t.addr);
      end
    endcase
  endtask

  initial begin : stimulus
    test_t       tests[$];
    string       line;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] expv;
    logic        err;
    int          fd;
    int          n;
    int          err_before;
    clock = 1'b0;
    reset_i = 1'b1;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i = 32'h0;
    req_wdata_i = 32'h0;
    req_wstrb_i = 4'h0;

    fd = $fopen("soc_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open soc_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if ((line.len() > 2) && (line[0] != "#")) begin
          n = $sscanf(line, "%s %h %h %h %h %h", op, addr, data, strb, expv, err);
          if (n == 6) begin
            tests.push_back('{op, addr, data, strb, expv, err});
          end
        end
      end
      $fclose(fd);
    end
    if (tests.size() == 0) begin
      errors++;
      $display("No tests were read from soc_testdata.txt");
    end
    cycle_limit = 200 * tests.size() + 20;

    repeat (8) @(posedge clock);
    #1 reset_i = 1'b0;
    err_before = errors;
    check_bit("req_ready_o after reset", req_ready_o, 1'b1);
    check_bit("resp_valid_o after reset", resp_valid_o, 1'b0);
    check_bit("io_master_awvalid_o after reset", io_master_awvalid_o, 1'b0);
    check_bit("io_master_wvalid_o after reset", io_master_wvalid_o, 1'b0);
    check_bit("io_master_arvalid_o after reset", io_master_arvalid_o, 1'b0);
    check_bit("io_master_bready_o after reset", io_master_bready_o, 1'b0);
    check_bit("io_master_rready_o after reset", io_master_rready_o, 1'b0);
    check_bit("timer_irq_o after reset", timer_irq_o, 1'b0);
    $display("test reset: %s", (errors == err_before) ? "ok" : "mismatch");

    foreach (tests[i]) begin
      err_before = errors;
      run_test(tests[i]);
      $display("test %0d %0s %h: %s", i, tests[i].op, tests[i].addr,
               (errors == err_before) ? "ok" : "mismatch");
    end

    $display("%0d tests, %0d checks, %0d errors", tests.size() + 1, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* soc_testdata.txt */
# op addr wdata strb expect err (all hex); expect is read data, or the cycle bound for cmp
# ops: wr write, rd read, tm rising mtime read, cmp arm mtimecmp ahead of mtime, irq level check
wr 80000000 aabbccdd f 00000000 0
wr 80000000 11223344 5 00000000 0
rd 80000000 00000000 0 aa22cc44 0
wr 80000010 00000000 f 00000000 0
wr 80000010 cafef00d c 00000000 0
rd 80000010 00000000 0 cafe0000 0
wr 800003fc 12345678 f 00000000 0
wr 800003fc 9abcdef0 2 00000000 0
rd 800003fc 00000000 0 1234de78 0
wr 80000040 01020304 f 00000000 0
wr 80000040 a0b0c0d0 9 00000000 0
rd 80000040 00000000 0 a00203d0 0
rd 0200bffc 00000000 0 00000000 0
tm 0200bff8 00000000 0 00000000 0
tm 0200bff8 00000000 0 00000000 0
rd 02004000 00000000 0 ffffffff 0
irq 00000000 00000000 0 00000000 0
cmp 02000000 00000028 f 00000064 0
irq 00000000 00000000 0 00000001 0
wr 02004004 ffffffff f 00000000 0
wr 02004000 ffffffff f 00000000 0
irq 00000000 00000000 0 00000000 0
rd 02000100 00000000 0 00000000 1
wr 0200bff8 12345678 f 00000000 1
rd 80000000 00000000 0 aa22cc44 0

/* project.f */
+incdir+.
soc_pkg.sv
soc_axi_if.sv
lsu_axi_bridge.sv
clint_xbar.sv
clint.sv
soc_top.sv
soc_axi_checker.sv
tb_soc_top.sv
